// File: verilog/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // address and data widths
    localparam int addr_w = 32;
    localparam int data_w = 32;

    // one lane per byte of the data word
    localparam int byte_w     = 8;
    localparam int n_lanes    = data_w / byte_w;
    localparam int lane_sel_w = 2;

    // words per byte bank, 4096 bytes per port
    localparam int bank_depth = 1024;
    localparam int word_idx_w = 10;

    // store size, one-hot style codes
    // unlisted codes behave as no store
    typedef enum logic [2:0] {
        st_none = 3'b000,
        st_byte = 3'b001,
        st_half = 3'b010,
        st_word = 3'b100
    } store_op_e;

    // request into one port
    typedef struct packed {
        logic                valid;
        logic [addr_w-1:0]   addr;
        logic [data_w-1:0]   wdata;
        store_op_e           store_op;
    } mem_req_t;

    // response out of one port
    typedef struct packed {
        logic                valid;
        logic [data_w-1:0]   rdata;
    } mem_rsp_t;

    // per-lane bank command built from a request
    typedef struct packed {
        logic                                en;
        logic [n_lanes-1:0]                  we;
        logic [n_lanes-1:0][word_idx_w-1:0]  word_idx;
        logic [n_lanes-1:0][byte_w-1:0]      wbyte;
    } lane_cmd_t;

endpackage

`default_nettype wire

// File: verilog/byte_bank.sv
`timescale 1ns/100ps
`default_nettype none

module byte_bank
    import mem_pkg::*;
(
    input  wire logic                  clk_1,
    input  wire logic                  cmd_en,
    input  wire logic                  we,
    input  wire logic [word_idx_w-1:0] word_idx,
    input  wire logic [byte_w-1:0]     wbyte,
    output logic      [byte_w-1:0]     rbyte
);

    // byte storage for one lane
    logic [byte_w-1:0] mem [bank_depth];

    // write port
    // only on an enabled edge with the lane selected for store
    always_ff @(posedge clk_1) begin
        if (cmd_en && we) begin
            mem[word_idx] <= wbyte;
        end
    end

    // registered read port
    // old content is sampled so a same-edge write shows up one request later
    // output keeps its last value while idle
    always_ff @(posedge clk_1) begin
        if (cmd_en) begin
            rbyte <= mem[word_idx];
        end
    end

endmodule

`default_nettype wire

// File: verilog/lane_steer.sv
`timescale 1ns/100ps
`default_nettype none

module lane_steer
    import mem_pkg::*;
(
    input  wire mem_req_t  req,
    output lane_cmd_t      cmd
);

    // byte offset inside the word
    logic [lane_sel_w-1:0] offset;
    // word index of the addressed byte and the one after it
    logic [word_idx_w-1:0] base_idx;
    logic [word_idx_w-1:0] next_idx;
    // store data split into bytes, byte 0 at addr
    logic [n_lanes-1:0][byte_w-1:0] data_bytes;
    // write mask before rotation by offset
    logic [n_lanes-1:0] mask_base;

    assign offset     = req.addr[lane_sel_w-1:0];
    assign base_idx   = req.addr[lane_sel_w +: word_idx_w];
    // wraps at bank_depth by the index width
    assign next_idx   = base_idx + word_idx_w'(1);
    assign data_bytes = req.wdata;

    // store size to unrotated mask
    always_comb begin
        case (req.store_op)
            st_byte: mask_base = 4'b0001;
            st_half: mask_base = 4'b0011;
            st_word: mask_base = 4'b1111;
            // st_none and unused codes
            default: mask_base = 4'b0000;
        endcase
    end

    // per-lane steering
    always_comb begin
        logic [lane_sel_w-1:0] rel;
        rel = '0;
        cmd.en = req.valid;
        for (int lane = 0; lane < n_lanes; lane++) begin
            // position of this lane within the access, 0 is the byte at addr
            rel = lane_sel_w'(lane) - offset;

            // lanes below the offset hold bytes of the following word
            if (lane_sel_w'(lane) < offset) begin
                cmd.word_idx[lane] = next_idx;
            end else begin
                cmd.word_idx[lane] = base_idx;
            end

            // store byte j lands on lane (offset + j) mod 4
            cmd.wbyte[lane] = data_bytes[rel];

            // mask rotated into place, nothing written without a request
            cmd.we[lane] = req.valid & mask_base[rel];
        end
    end

endmodule

`default_nettype wire

// File: verilog/read_align.sv
`timescale 1ns/100ps
`default_nettype none

module read_align
    import mem_pkg::*;
(
    input  wire logic                           clk_1,
    input  wire logic                           rst_n_sync,
    input  wire logic                           req_valid,
    input  wire logic [lane_sel_w-1:0]          offset,
    input  wire logic [n_lanes-1:0][byte_w-1:0] lane_bytes,
    output mem_rsp_t                            rsp
);

    // response valid, one cycle behind the request
    logic valid_q;
    // offset of the request being answered
    logic [lane_sel_w-1:0] offset_q;

    always_ff @(posedge clk_1 or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_valid;
        end
    end

    // only follows accepted requests
    always_ff @(posedge clk_1) begin
        if (req_valid) begin
            offset_q <= offset;
        end
    end

    // rotate lanes back so the byte at addr sits in bits 7:0
    always_comb begin
        logic [lane_sel_w-1:0] lane;
        lane = '0;
        rsp.valid = valid_q;
        for (int j = 0; j < n_lanes; j++) begin
            lane = offset_q + lane_sel_w'(j);
            rsp.rdata[j*byte_w +: byte_w] = lane_bytes[lane];
        end
    end

endmodule

`default_nettype wire

// File: verilog/mem_port.sv
`timescale 1ns/100ps
`default_nettype none

module mem_port
    import mem_pkg::*;
(
    input  wire logic     clk_1,
    input  wire logic     rst_n_sync,
    input  wire mem_req_t req,
    output mem_rsp_t      rsp
);

    // bank command for all four lanes
    lane_cmd_t cmd;
    // raw bank outputs in lane order
    logic [n_lanes-1:0][byte_w-1:0] lane_bytes;

    // address split, mask decode and write data rotation
    lane_steer u_steer (
        .req (req),
        .cmd (cmd)
    );

    // one byte-wide bank per lane
    // lane index equals byte address mod 4
    for (genvar lane = 0; lane < n_lanes; lane++) begin : g_lane
        byte_bank u_bank (
            .clk_1    (clk_1),
            .cmd_en   (cmd.en),
            .we       (cmd.we[lane]),
            .word_idx (cmd.word_idx[lane]),
            .wbyte    (cmd.wbyte[lane]),
            .rbyte    (lane_bytes[lane])
        );
    end

    // response valid and read data rotation
    read_align u_align (
        .clk_1      (clk_1),
        .rst_n_sync (rst_n_sync),
        .req_valid  (cmd.en),
        .offset     (req.addr[lane_sel_w-1:0]),
        .lane_bytes (lane_bytes),
        .rsp        (rsp)
    );

endmodule

`default_nettype wire

// File: verilog/mem_interface.sv
`timescale 1ns/100ps
`default_nettype none

module mem_interface
    import mem_pkg::*;
(
    input  wire logic     clk_1,
    input  wire logic     rst_n_sync,
    // instruction side
    input  wire mem_req_t imem_req,
    output mem_rsp_t      imem_rsp,
    // data side
    input  wire mem_req_t dmem_req,
    output mem_rsp_t      dmem_rsp
);

    // instruction port
    // own banks, no sharing with the data port
    mem_port u_imem (
        .clk_1      (clk_1),
        .rst_n_sync (rst_n_sync),
        .req        (imem_req),
        .rsp        (imem_rsp)
    );

    // data port
    // same structure, fully independent timing
    mem_port u_dmem (
        .clk_1      (clk_1),
        .rst_n_sync (rst_n_sync),
        .req        (dmem_req),
        .rsp        (dmem_rsp)
    );

endmodule

`default_nettype wire

// File: dv/mem_interface_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mem_interface_tb
    import mem_pkg::*;
();

    // stimulus sizes
    localparam int n_aligned = 16;
    localparam int n_random  = 500;
    // reset, idles, sweep, directed phases, random phase, drains
    localparam int n_cycles = 3 + 3 + 8 + bank_depth + 2 * n_aligned + 16 + 18 + n_random + 14;
    localparam int watchdog_ns = (n_cycles + 50) * 100;

    logic     clk_1;
    logic     rst_n_sync;
    mem_req_t imem_req;
    mem_req_t dmem_req;
    mem_rsp_t imem_rsp;
    mem_rsp_t dmem_rsp;

    // byte model per port, index 0 is imem
    logic [byte_w-1:0] model_mem [2][4096];
    // expected responses: {check data, due cycle, rdata}
    logic [63:0] exp_i [$];
    logic [63:0] exp_d [$];

    logic [30:0] cycle_count = '0;
    // low while bank contents are still unknown
    logic        data_known;
    string       test_name;
    int          err_count;
    integer      seed = 32'h61fde847;

    mem_interface dut (
        .clk_1      (clk_1),
        .rst_n_sync (rst_n_sync),
        .imem_req   (imem_req),
        .imem_rsp   (imem_rsp),
        .dmem_req   (dmem_req),
        .dmem_rsp   (dmem_rsp)
    );

    initial begin
        clk_1 = 1'b0;
        forever #50 clk_1 = ~clk_1;
    end

    // cycle stamp for the response timing
    always @(posedge clk_1) begin
        cycle_count <= cycle_count + 31'd1;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            err_count++;
            $display("error: %s expected %h actual %h", name, expected, actual);
            $display("test failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic mem_req_t make_req(input logic valid, input logic [11:0] addr,
                                          input logic [31:0] wdata, input store_op_e op);
        mem_req_t r;
        r.valid    = valid;
        r.addr     = {20'd0, addr};
        r.wdata    = wdata;
        r.store_op = op;
        return r;
    endfunction

    // predict read-first data, then apply the store
    task automatic model_request(input logic port, input mem_req_t r);
        logic [11:0] a;
        logic [31:0] rd;
        int          n;
        a  = r.addr[11:0];
        rd = '0;
        n  = 0;
        if (r.valid) begin
            // byte at addr in bits 7:0, wraps at 4096
            for (int j = 0; j < 4; j++) begin
                rd[j*8 +: 8] = model_mem[port][a + 12'(j)];
            end
            // accepted at the next edge, answered in the cycle after it
            if (port) begin
                exp_d.push_back({data_known, cycle_count + 31'd1, rd});
            end else begin
                exp_i.push_back({data_known, cycle_count + 31'd1, rd});
            end
            case (r.store_op)
                st_byte: n = 1;
                st_half: n = 2;
                st_word: n = 4;
                default: n = 0;
            endcase
            for (int j = 0; j < n; j++) begin
                model_mem[port][a + 12'(j)] = r.wdata[j*8 +: 8];
            end
        end
    endtask

    // one cycle of requests on both ports
    task automatic drive_cycle(input mem_req_t ireq, input mem_req_t dreq);
        @(posedge clk_1);
        #1;
        imem_req = ireq;
        dmem_req = dreq;
        model_request(1'b0, ireq);
        model_request(1'b1, dreq);
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            drive_cycle('0, '0);
        end
    endtask

    // valid must match the model cycle exactly, data only once known
    task automatic check_port(input logic port, input mem_rsp_t rsp);
        logic [63:0] head;
        logic        has;
        logic        due;
        string       side;
        head = '0;
        side = port ? "dmem" : "imem";
        if (port) begin
            has = (exp_d.size() != 0);
            if (has) head = exp_d[0];
        end else begin
            has = (exp_i.size() != 0);
            if (has) head = exp_i[0];
        end
        due = has && (head[62:32] == cycle_count);
        check_value({test_name, " ", side, " valid"}, {31'd0, due}, {31'd0, rsp.valid});
        if (due) begin
            if (head[63]) begin
                check_value({test_name, " ", side, " rdata"}, head[31:0], rsp.rdata);
            end
            if (port) begin
                void'(exp_d.pop_front());
            end else begin
                void'(exp_i.pop_front());
            end
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk_1) begin
        check_port(1'b0, imem_rsp);
        check_port(1'b1, dmem_rsp);
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: run did not finish within %0d ns", watchdog_ns);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [11:0] addrs [n_aligned];
        logic [11:0] a;
        logic [11:0] base;
        store_op_e   op;
        err_count  = 0;
        data_known = 1'b0;
        test_name  = "reset";
        rst_n_sync = 1'b0;
        imem_req   = '0;
        dmem_req   = '0;
        repeat (3) @(posedge clk_1);
        #1;
        rst_n_sync = 1'b1;
        // no response may appear without a request
        idle_cycles(3);

        // single requests with idles around them
        test_name = "single";
        drive_cycle(make_req(1'b1, 12'h010, 32'd0, st_none), '0);
        idle_cycles(3);
        drive_cycle('0, make_req(1'b1, 12'h020, 32'd0, st_none));
        idle_cycles(3);

        // fill every word so later reads are defined
        test_name = "sweep";
        for (int w = 0; w < bank_depth; w++) begin
            drive_cycle(make_req(1'b1, 12'(w * 4), 32'($random(seed)), st_word),
                        make_req(1'b1, 12'(w * 4), 32'($random(seed)), st_word));
        end
        idle_cycles(2);
        data_known = 1'b1;

        test_name = "aligned";
        for (int i = 0; i < n_aligned; i++) begin
            addrs[i] = 12'($random(seed)) & 12'hffc;
            drive_cycle(make_req(1'b1, addrs[i], 32'($random(seed)), st_word),
                        make_req(1'b1, addrs[i], 32'($random(seed)), st_word));
        end
        for (int i = 0; i < n_aligned; i++) begin
            drive_cycle(make_req(1'b1, addrs[i], 32'd0, st_none),
                        make_req(1'b1, addrs[i], 32'd0, st_none));
        end
        idle_cycles(2);

        // byte and halfword stores at each offset, read back as a word
        test_name = "subword";
        for (int off = 0; off < 4; off++) begin
            for (int k = 0; k < 2; k++) begin
                op   = (k == 0) ? st_byte : st_half;
                base = 12'($random(seed)) & 12'hffc;
                a    = base | 12'(off);
                drive_cycle(make_req(1'b1, a, 32'($random(seed)), op),
                            make_req(1'b1, a, 32'($random(seed)), op));
                drive_cycle(make_req(1'b1, base, 32'd0, st_none),
                            make_req(1'b1, base, 32'd0, st_none));
            end
        end
        idle_cycles(2);

        // top three addresses wrap into word 0
        test_name = "misaligned";
        for (int i = 0; i < 6; i++) begin
            if (i < 3) begin
                a = 12'(4093 + i);
            end else begin
                a = (12'($random(seed)) & 12'hffc) | 12'(i - 2);
            end
            drive_cycle(make_req(1'b1, a, 32'($random(seed)), st_word),
                        make_req(1'b1, a, 32'($random(seed)), st_word));
            drive_cycle(make_req(1'b1, a, 32'd0, st_none),
                        make_req(1'b1, a, 32'd0, st_none));
            drive_cycle(make_req(1'b1, a & 12'hffc, 32'd0, st_none),
                        make_req(1'b1, a & 12'hffc, 32'd0, st_none));
        end
        idle_cycles(2);

        // back to back, unused store codes included
        test_name = "random";
        for (int i = 0; i < n_random; i++) begin
            drive_cycle(make_req((($random(seed) & 3) != 0), 12'($random(seed)),
                                 32'($random(seed)), store_op_e'(3'($random(seed) & 7))),
                        make_req((($random(seed) & 3) != 0), 12'($random(seed)),
                                 32'($random(seed)), store_op_e'(3'($random(seed) & 7))));
        end

        test_name = "drain";
        idle_cycles(4);
        check_value("drain imem pending", 32'd0, 32'(exp_i.size()));
        check_value("drain dmem pending", 32'd0, 32'(exp_d.size()));

        if (err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
verilog/mem_pkg.sv
verilog/byte_bank.sv
verilog/lane_steer.sv
verilog/read_align.sv
verilog/mem_port.sv
verilog/mem_interface.sv
dv/mem_interface_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run with Verilator, result taken from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -f build.f --top-module mem_interface_tb > build.log 2>&1 \
    && ./obj_dir/Vmem_interface_tb > sim.log 2>&1
grep -qx "test passed" sim.log && echo "simulation PASS" \
    || { echo "simulation FAIL, see build.log and sim.log"; exit 1; }
exit 0
